//--- hw/sd_reg_pkg.sv
package sd_reg_pkg;

   typedef logic [15:0]  reg_addr_t;
   typedef logic [31:0]  reg_data_t;
   typedef logic [3:0]   speed_t;
   typedef logic [119:0] card_id_t;
   typedef logic [15:0]  cmd_code_t;

   // host writable registers
   localparam reg_addr_t OFS_COMMAND      = 16'h0000;
   localparam reg_addr_t OFS_SPEED        = 16'h0004;
   localparam reg_addr_t OFS_SD_ADDR      = 16'h0008;
   localparam reg_addr_t OFS_DDR_ADDR     = 16'h000c;
   localparam reg_addr_t OFS_SECTOR       = 16'h0010;
   localparam reg_addr_t OFS_RESET        = 16'h0018;
   localparam reg_addr_t OFS_POWER        = 16'h001c;
   localparam reg_addr_t OFS_DATA_TYPE    = 16'h005c;

   // read-only engine status
   localparam reg_addr_t OFS_LINK_STATUS  = 16'h0020;
   localparam reg_addr_t OFS_TRANS_STATUS = 16'h0024;
   localparam reg_addr_t OFS_RCA          = 16'h002c;
   localparam reg_addr_t OFS_CID0         = 16'h0030;
   localparam reg_addr_t OFS_CID1         = 16'h0034;
   localparam reg_addr_t OFS_CID2         = 16'h0038;
   localparam reg_addr_t OFS_CID3         = 16'h003c;
   localparam reg_addr_t OFS_CSD0         = 16'h0040;
   localparam reg_addr_t OFS_CSD1         = 16'h0044;
   localparam reg_addr_t OFS_CSD2         = 16'h0048;
   localparam reg_addr_t OFS_CSD3         = 16'h004c;
   localparam reg_addr_t OFS_RD_COUNT     = 16'h0050;
   localparam reg_addr_t OFS_WR_COUNT     = 16'h0054;
   localparam reg_addr_t OFS_BURST_DONE   = 16'h0058;
   localparam reg_addr_t OFS_R1_RESP      = 16'h012c;

   // one 1080p RGBA frame in 512-byte sectors
   localparam reg_data_t RST_SECTOR_SIZE  = 32'd16201;
   localparam reg_data_t RST_SD_ADDR      = 32'd24832;
   localparam reg_data_t RST_DDR_ADDR     = 32'h8000_0000;
   localparam reg_data_t RST_DATA_TYPE    = 32'h0000_424d;
   localparam logic      RST_SD_RST       = 1'b1;

   localparam cmd_code_t CMD_INIT         = 16'd1;
   localparam cmd_code_t CMD_READ         = 16'd2;
   localparam cmd_code_t CMD_WRITE        = 16'd3;

   // pulse length in cycles shortened for simulation
   localparam int PULSE_CYCLES   = 32;
   localparam int PULSE_CHANNELS = 2;

   typedef logic [$clog2(PULSE_CYCLES)-1:0] pulse_cnt_t;

   localparam pulse_cnt_t PULSE_LAST = pulse_cnt_t'(PULSE_CYCLES - 1);

   typedef struct packed {
      logic      psel;
      logic      penable;
      logic      pwrite;
      reg_addr_t paddr;
      reg_data_t pwdata;
   } apb_req_t;

   typedef struct packed {
      logic      pready;
      reg_data_t prdata;
      logic      pslverr;
   } apb_rsp_t;

   typedef struct packed {
      speed_t    speed;
      reg_data_t sector_size;
      reg_data_t sd_addr;
      reg_data_t ddr_addr;
      logic      sd_rst;
      logic      sd_power;
      reg_data_t data_type;
   } sd_cfg_t;

   typedef struct packed {
      logic        cs_n;
      logic [10:0] initial_status;
      logic [7:0]  trans_status;
      logic [15:0] rca;
      card_id_t    cid;
      card_id_t    csd;
      reg_data_t   r1_resp;
      reg_data_t   rd_count;
      reg_data_t   wr_count;
      logic        burst_done;
   } sd_status_t;

   // one strobe per writable register
   typedef struct packed {
      logic      cmd;
      logic      speed;
      logic      sd_addr;
      logic      ddr_addr;
      logic      sector;
      logic      sd_rst;
      logic      power;
      logic      data_type;
      reg_data_t wdata;
   } reg_wr_t;

   // sel is 0 for read and 1 for write
   typedef struct packed {
      logic valid;
      logic init;
      logic start;
      logic sel;
   } cmd_t;

   typedef enum logic {
      PULSE_IDLE,
      PULSE_ACTIVE
   } pulse_state_e;

endpackage

//--- hw/sd_apb_decode.sv
`timescale 1ns/100ps

module sd_apb_decode (
   input  logic                   i_clk,
   input  logic                   i_rst_n,
   input  sd_reg_pkg::apb_req_t   i_apb,
   output sd_reg_pkg::apb_rsp_t   o_apb,
   input  sd_reg_pkg::sd_status_t i_status,
   input  sd_reg_pkg::sd_cfg_t    i_cfg,
   output sd_reg_pkg::reg_wr_t    o_wr
);

   import sd_reg_pkg::*;

   logic      r_setup;
   logic      w_access;
   logic      w_wr_acc;
   logic      w_rd_acc;
   logic      w_wr_hit;
   logic      w_rd_hit;
   reg_data_t w_rd_data;

   // word 0 carries the low 24 bits moved up by one byte
   function automatic reg_data_t card_word(input card_id_t id, input logic [1:0] idx);
      case (idx)
         2'd0:    card_word = {id[23:0], 8'd0};
         2'd1:    card_word = id[55:24];
         2'd2:    card_word = id[87:56];
         default: card_word = id[119:88];
      endcase
   endfunction

   // access phase only counts after a setup phase
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         r_setup <= 1'b0;
      end else begin
         r_setup <= i_apb.psel & ~i_apb.penable;
      end
   end

   assign w_access = i_apb.psel & i_apb.penable & r_setup;
   assign w_wr_acc = w_access & i_apb.pwrite;
   assign w_rd_acc = w_access & ~i_apb.pwrite;

   // write strobes
   always_comb begin
      o_wr       = '0;
      o_wr.wdata = i_apb.pwdata;
      w_wr_hit   = 1'b1;
      case (i_apb.paddr)
         OFS_COMMAND:   o_wr.cmd       = w_wr_acc;
         OFS_SPEED:     o_wr.speed     = w_wr_acc;
         OFS_SD_ADDR:   o_wr.sd_addr   = w_wr_acc;
         OFS_DDR_ADDR:  o_wr.ddr_addr  = w_wr_acc;
         OFS_SECTOR:    o_wr.sector    = w_wr_acc;
         OFS_RESET:     o_wr.sd_rst    = w_wr_acc;
         OFS_POWER:     o_wr.power     = w_wr_acc;
         OFS_DATA_TYPE: o_wr.data_type = w_wr_acc;
         default:       w_wr_hit       = 1'b0;
      endcase
   end

   // read mux with unnamed bits held at zero
   always_comb begin
      w_rd_data = '0;
      w_rd_hit  = 1'b1;
      case (i_apb.paddr)
         OFS_LINK_STATUS:  w_rd_data = {i_status.cs_n, 20'd0, i_status.initial_status};
         OFS_TRANS_STATUS: w_rd_data = {24'd0, i_status.trans_status};
         OFS_RCA:          w_rd_data = {16'd0, i_status.rca};
         OFS_CID0, OFS_CID1, OFS_CID2, OFS_CID3: begin
            w_rd_data = card_word(i_status.cid, i_apb.paddr[3:2]);
         end
         OFS_CSD0, OFS_CSD1, OFS_CSD2, OFS_CSD3: begin
            w_rd_data = card_word(i_status.csd, i_apb.paddr[3:2]);
         end
         OFS_R1_RESP:      w_rd_data = i_status.r1_resp;
         OFS_RD_COUNT:     w_rd_data = i_status.rd_count;
         OFS_WR_COUNT:     w_rd_data = i_status.wr_count;
         OFS_BURST_DONE:   w_rd_data = {31'd0, i_status.burst_done};
         OFS_DATA_TYPE:    w_rd_data = i_cfg.data_type;
         default:          w_rd_hit  = 1'b0;
      endcase
   end

   // no wait states
   assign o_apb.pready  = 1'b1;
   assign o_apb.prdata  = w_rd_acc ? w_rd_data : '0;
   assign o_apb.pslverr = w_access & (i_apb.pwrite ? ~w_wr_hit : ~w_rd_hit);

endmodule

//--- hw/sd_cfg_regs.sv
`timescale 1ns/100ps

module sd_cfg_regs (
   input  logic                i_clk,
   input  logic                i_rst_n,
   input  sd_reg_pkg::reg_wr_t i_wr,
   output sd_reg_pkg::sd_cfg_t o_cfg,
   output sd_reg_pkg::cmd_t    o_cmd
);

   import sd_reg_pkg::*;

   cmd_t w_cmd_next;

   // configuration registers
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_cfg.speed       <= '0;
         o_cfg.sector_size <= RST_SECTOR_SIZE;
         o_cfg.sd_addr     <= RST_SD_ADDR;
         o_cfg.ddr_addr    <= RST_DDR_ADDR;
         o_cfg.sd_rst      <= RST_SD_RST;
         o_cfg.sd_power    <= 1'b0;
         o_cfg.data_type   <= RST_DATA_TYPE;
      end else begin
         if (i_wr.speed) begin
            o_cfg.speed <= i_wr.wdata[$bits(speed_t)-1:0];
         end
         if (i_wr.sector) begin
            o_cfg.sector_size <= i_wr.wdata;
         end
         if (i_wr.sd_addr) begin
            o_cfg.sd_addr <= i_wr.wdata;
         end
         if (i_wr.ddr_addr) begin
            o_cfg.ddr_addr <= i_wr.wdata;
         end
         // single-bit controls take bit 0
         if (i_wr.sd_rst) begin
            o_cfg.sd_rst <= i_wr.wdata[0];
         end
         if (i_wr.power) begin
            o_cfg.sd_power <= i_wr.wdata[0];
         end
         if (i_wr.data_type) begin
            o_cfg.data_type <= i_wr.wdata;
         end
      end
   end

   // command code lives in the low half-word
   always_comb begin
      w_cmd_next = '0;
      if (i_wr.cmd) begin
         case (cmd_code_t'(i_wr.wdata[15:0]))
            CMD_INIT: begin
               w_cmd_next.valid = 1'b1;
               w_cmd_next.init  = 1'b1;
            end
            CMD_READ: begin
               w_cmd_next.valid = 1'b1;
               w_cmd_next.start = 1'b1;
               w_cmd_next.sel   = 1'b0;
            end
            CMD_WRITE: begin
               w_cmd_next.valid = 1'b1;
               w_cmd_next.start = 1'b1;
               w_cmd_next.sel   = 1'b1;
            end
            default: w_cmd_next = '0;
         endcase
      end
   end

   // one-cycle command to the pulse stage
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_cmd <= '0;
      end else begin
         o_cmd <= w_cmd_next;
      end
   end

endmodule

//--- hw/sd_cmd_pulse.sv
`timescale 1ns/100ps

module sd_cmd_pulse (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  sd_reg_pkg::cmd_t      i_cmd,
   input  sd_reg_pkg::reg_data_t i_sd_addr,
   output logic                  o_initial_en,
   output logic                  o_trans_start,
   output logic                  o_trans_sel,
   output sd_reg_pkg::reg_data_t o_trans_addr
);

   import sd_reg_pkg::*;

   // channel 0 is init and channel 1 is transfer start
   pulse_state_e              r_state [PULSE_CHANNELS];
   pulse_cnt_t                r_cnt   [PULSE_CHANNELS];
   logic [PULSE_CHANNELS-1:0] w_trig;

   assign w_trig[0] = i_cmd.valid & i_cmd.init;
   assign w_trig[1] = i_cmd.valid & i_cmd.start;

   // counter runs PULSE_LAST down to 0 and a new trigger reloads it
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < PULSE_CHANNELS; i++) begin
            r_state[i] <= PULSE_IDLE;
            r_cnt[i]   <= '0;
         end
      end else begin
         for (int i = 0; i < PULSE_CHANNELS; i++) begin
            case (r_state[i])
               PULSE_IDLE: begin
                  if (w_trig[i]) begin
                     r_state[i] <= PULSE_ACTIVE;
                     r_cnt[i]   <= PULSE_LAST;
                  end
               end
               PULSE_ACTIVE: begin
                  if (w_trig[i]) begin
                     r_cnt[i] <= PULSE_LAST;
                  end else if (r_cnt[i] == '0) begin
                     r_state[i] <= PULSE_IDLE;
                  end else begin
                     r_cnt[i] <= r_cnt[i] - pulse_cnt_t'(1);
                  end
               end
               default: r_state[i] <= PULSE_IDLE;
            endcase
         end
      end
   end

   // hold direction and card address for the whole transfer
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_trans_sel  <= 1'b0;
         o_trans_addr <= '0;
      end else if (w_trig[1]) begin
         o_trans_sel  <= i_cmd.sel;
         o_trans_addr <= i_sd_addr;
      end
   end

   assign o_initial_en  = (r_state[0] == PULSE_ACTIVE);
   assign o_trans_start = (r_state[1] == PULSE_ACTIVE);

endmodule

//--- hw/sd_reg_top.sv
`timescale 1ns/100ps

module sd_reg_top (
   input  logic                   i_clk,
   input  logic                   i_rst_n,
   input  sd_reg_pkg::apb_req_t   i_apb,
   output sd_reg_pkg::apb_rsp_t   o_apb,
   input  sd_reg_pkg::sd_status_t i_status,
   output sd_reg_pkg::sd_cfg_t    o_cfg,
   output logic                   o_initial_en,
   output logic                   o_trans_start,
   output logic                   o_trans_sel,
   output sd_reg_pkg::reg_data_t  o_trans_addr
);

   import sd_reg_pkg::*;

   reg_wr_t w_wr;
   sd_cfg_t w_cfg;
   cmd_t    w_cmd;

   // bus side
   sd_apb_decode u_apb_decode (
      .i_clk    (i_clk),
      .i_rst_n  (i_rst_n),
      .i_apb    (i_apb),
      .o_apb    (o_apb),
      .i_status (i_status),
      .i_cfg    (w_cfg),
      .o_wr     (w_wr)
   );

   sd_cfg_regs u_cfg_regs (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_wr    (w_wr),
      .o_cfg   (w_cfg),
      .o_cmd   (w_cmd)
   );

   // engine side
   sd_cmd_pulse u_cmd_pulse (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_cmd         (w_cmd),
      .i_sd_addr     (w_cfg.sd_addr),
      .o_initial_en  (o_initial_en),
      .o_trans_start (o_trans_start),
      .o_trans_sel   (o_trans_sel),
      .o_trans_addr  (o_trans_addr)
   );

   assign o_cfg = w_cfg;

endmodule

//--- tb/sd_reg_checker.sv
`timescale 1ns/100ps

module sd_reg_checker (
   input  logic                   i_clk,
   input  logic                   i_rst_n,
   input  sd_reg_pkg::apb_req_t   i_apb,
   input  sd_reg_pkg::apb_rsp_t   i_apb_rsp,
   input  sd_reg_pkg::sd_status_t i_status,
   input  sd_reg_pkg::sd_cfg_t    i_cfg,
   input  logic                   i_initial_en,
   input  logic                   i_trans_start,
   input  logic                   i_trans_sel,
   input  sd_reg_pkg::reg_data_t  i_trans_addr,
   output int                     o_errors,
   output int                     o_checks
);

   import sd_reg_pkg::*;

   typedef struct packed {
      logic      err;
      reg_data_t data;
   } rd_exp_t;

   int        errors_cnt = 0;
   int        checks_cnt = 0;
   sd_cfg_t   shadow;
   logic      setup_seen;
   logic      in_access;
   logic      wr_accepted;
   rd_exp_t   exp_rd;
   logic      init_d1;
   logic      start_d1;
   logic      sel_d1;
   int        init_rem;
   int        start_rem;
   logic      exp_sel;
   reg_data_t exp_addr;

   function automatic logic is_writable(input reg_addr_t addr);
      case (addr)
         OFS_COMMAND, OFS_SPEED, OFS_SD_ADDR, OFS_DDR_ADDR, OFS_SECTOR,
         OFS_RESET, OFS_POWER, OFS_DATA_TYPE: is_writable = 1'b1;
         default: is_writable = 1'b0;
      endcase
   endfunction

   // expected prdata and pslverr for one access phase
   function automatic rd_exp_t expected_read(input reg_addr_t addr, input logic wr,
                                             input sd_cfg_t cfg, input sd_status_t st);
      logic [127:0] cid_ext;
      logic [127:0] csd_ext;
      rd_exp_t      r;
      // ids padded by a zero byte below and cut into words
      cid_ext = {st.cid, 8'h00};
      csd_ext = {st.csd, 8'h00};
      r       = '0;
      if (wr) begin
         r.err = ~is_writable(addr);
      end else begin
         case (addr)
            OFS_LINK_STATUS: begin
               r.data[31]   = st.cs_n;
               r.data[10:0] = st.initial_status;
            end
            OFS_TRANS_STATUS: r.data[7:0]  = st.trans_status;
            OFS_RCA:          r.data[15:0] = st.rca;
            OFS_CID0:         r.data = cid_ext[31:0];
            OFS_CID1:         r.data = cid_ext[63:32];
            OFS_CID2:         r.data = cid_ext[95:64];
            OFS_CID3:         r.data = cid_ext[127:96];
            OFS_CSD0:         r.data = csd_ext[31:0];
            OFS_CSD1:         r.data = csd_ext[63:32];
            OFS_CSD2:         r.data = csd_ext[95:64];
            OFS_CSD3:         r.data = csd_ext[127:96];
            OFS_RD_COUNT:     r.data = st.rd_count;
            OFS_WR_COUNT:     r.data = st.wr_count;
            OFS_R1_RESP:      r.data = st.r1_resp;
            OFS_BURST_DONE:   r.data[0] = st.burst_done;
            OFS_DATA_TYPE:    r.data = cfg.data_type;
            default:          r.err = 1'b1;
         endcase
      end
      return r;
   endfunction

   task automatic compare(input string name, input reg_data_t exp, input reg_data_t act);
      checks_cnt++;
      if (exp !== act) begin
         errors_cnt++;
         $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   assign in_access   = setup_seen & i_apb.psel & i_apb.penable;
   assign wr_accepted = in_access & i_apb.pwrite & is_writable(i_apb.paddr);
   assign exp_rd      = expected_read(i_apb.paddr, i_apb.pwrite, shadow, i_status);

   always @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         shadow.speed       <= '0;
         shadow.sector_size <= RST_SECTOR_SIZE;
         shadow.sd_addr     <= RST_SD_ADDR;
         shadow.ddr_addr    <= RST_DDR_ADDR;
         shadow.sd_rst      <= RST_SD_RST;
         shadow.sd_power    <= 1'b0;
         shadow.data_type   <= RST_DATA_TYPE;
         setup_seen         <= 1'b0;
         init_d1            <= 1'b0;
         start_d1           <= 1'b0;
         sel_d1             <= 1'b0;
         init_rem           <= 0;
         start_rem          <= 0;
         exp_sel            <= 1'b0;
         exp_addr           <= '0;
      end else begin
         if (in_access) begin
            compare("pready", 32'd1, {31'd0, i_apb_rsp.pready});
            compare("prdata", exp_rd.data, i_apb_rsp.prdata);
            compare("pslverr", {31'd0, exp_rd.err}, {31'd0, i_apb_rsp.pslverr});
         end
         compare("o_cfg.speed", {28'd0, shadow.speed}, {28'd0, i_cfg.speed});
         compare("o_cfg.sector_size", shadow.sector_size, i_cfg.sector_size);
         compare("o_cfg.sd_addr", shadow.sd_addr, i_cfg.sd_addr);
         compare("o_cfg.ddr_addr", shadow.ddr_addr, i_cfg.ddr_addr);
         compare("o_cfg.sd_rst", {31'd0, shadow.sd_rst}, {31'd0, i_cfg.sd_rst});
         compare("o_cfg.sd_power", {31'd0, shadow.sd_power}, {31'd0, i_cfg.sd_power});
         compare("o_cfg.data_type", shadow.data_type, i_cfg.data_type);
         compare("o_initial_en", {31'd0, init_rem != 0}, {31'd0, i_initial_en});
         compare("o_trans_start", {31'd0, start_rem != 0}, {31'd0, i_trans_start});
         compare("o_trans_sel", {31'd0, exp_sel}, {31'd0, i_trans_sel});
         compare("o_trans_addr", exp_addr, i_trans_addr);

         setup_seen <= i_apb.psel & ~i_apb.penable;
         init_d1    <= 1'b0;
         start_d1   <= 1'b0;
         if (wr_accepted) begin
            case (i_apb.paddr)
               OFS_SPEED:     shadow.speed       <= i_apb.pwdata[3:0];
               OFS_SD_ADDR:   shadow.sd_addr     <= i_apb.pwdata;
               OFS_DDR_ADDR:  shadow.ddr_addr    <= i_apb.pwdata;
               OFS_SECTOR:    shadow.sector_size <= i_apb.pwdata;
               OFS_RESET:     shadow.sd_rst      <= i_apb.pwdata[0];
               OFS_POWER:     shadow.sd_power    <= i_apb.pwdata[0];
               OFS_DATA_TYPE: shadow.data_type   <= i_apb.pwdata;
               OFS_COMMAND: begin
                  init_d1  <= (i_apb.pwdata[15:0] == CMD_INIT);
                  start_d1 <= (i_apb.pwdata[15:0] == CMD_READ) ||
                              (i_apb.pwdata[15:0] == CMD_WRITE);
                  sel_d1   <= (i_apb.pwdata[15:0] == CMD_WRITE);
               end
               default: ;
            endcase
         end

         // pulse rises one edge after the command stage and a retrigger reloads it
         if (init_d1) begin
            init_rem <= PULSE_CYCLES;
         end else if (init_rem != 0) begin
            init_rem <= init_rem - 1;
         end
         if (start_d1) begin
            start_rem <= PULSE_CYCLES;
            exp_sel   <= sel_d1;
            exp_addr  <= shadow.sd_addr;
         end else if (start_rem != 0) begin
            start_rem <= start_rem - 1;
         end
      end
   end

   assign o_errors = errors_cnt;
   assign o_checks = checks_cnt;

endmodule

//--- tb/sd_reg_tb.sv
`timescale 1ns/100ps

module sd_reg_tb;

   import sd_reg_pkg::*;

   // the sequence runs well under a thousand cycles
   localparam int TIMEOUT_CYCLES = 20000;

   logic       clk;
   logic       rst_n;
   apb_req_t   apb;
   apb_rsp_t   apb_rsp;
   sd_status_t status;
   sd_cfg_t    cfg;
   logic       initial_en;
   logic       trans_start;
   logic       trans_sel;
   reg_data_t  trans_addr;
   reg_data_t  seed;
   int         errors;
   int         checks;
   int         errors_mark;
   int         cycles = 0;

   sd_reg_top DUT (
      .i_clk         (clk),
      .i_rst_n       (rst_n),
      .i_apb         (apb),
      .o_apb         (apb_rsp),
      .i_status      (status),
      .o_cfg         (cfg),
      .o_initial_en  (initial_en),
      .o_trans_start (trans_start),
      .o_trans_sel   (trans_sel),
      .o_trans_addr  (trans_addr)
   );

   sd_reg_checker u_checker (
      .i_clk         (clk),
      .i_rst_n       (rst_n),
      .i_apb         (apb),
      .i_apb_rsp     (apb_rsp),
      .i_status      (status),
      .i_cfg         (cfg),
      .i_initial_en  (initial_en),
      .i_trans_start (trans_start),
      .i_trans_sel   (trans_sel),
      .i_trans_addr  (trans_addr),
      .o_errors      (errors),
      .o_checks      (checks)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, the test sequence did not complete", cycles);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   function automatic reg_data_t xorshift32(input reg_data_t s);
      reg_data_t x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic reg_data_t next_rand();
      seed = xorshift32(seed);
      return seed;
   endfunction

   // starts on a falling edge and returns on the falling edge after the access phase
   task automatic apb_access(input logic wr, input reg_addr_t addr, input reg_data_t data);
      apb.psel    = 1'b1;
      apb.penable = 1'b0;
      apb.pwrite  = wr;
      apb.paddr   = addr;
      apb.pwdata  = data;
      @(negedge clk);
      apb.penable = 1'b1;
      @(negedge clk);
      apb.psel    = 1'b0;
      apb.penable = 1'b0;
   endtask

   task automatic apb_write(input reg_addr_t addr, input reg_data_t data);
      apb_access(1'b1, addr, data);
   endtask

   task automatic apb_read(input reg_addr_t addr);
      apb_access(1'b0, addr, '0);
   endtask

   task automatic randomize_status();
      logic [383:0] bits;
      for (int k = 0; k < 12; k++) begin
         bits[32*k +: 32] = next_rand();
      end
      status = sd_status_t'(bits[$bits(sd_status_t)-1:0]);
   endtask

   // waits for the selected pulse to rise and fall again
   task automatic wait_pulse_end(input logic trans);
      while ((trans ? trans_start : initial_en) == 1'b0) @(negedge clk);
      while ((trans ? trans_start : initial_en) == 1'b1) @(negedge clk);
   endtask

   task automatic end_test(input string name);
      @(negedge clk);
      $display("test %s: %0d mismatches", name, errors - errors_mark);
      errors_mark = errors;
   endtask

   initial begin
      rst_n       = 1'b0;
      apb         = '0;
      status      = '0;
      seed        = 32'hab3a;
      errors_mark = 0;
      repeat (5) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);

      apb_read(OFS_DATA_TYPE);
      end_test("reset_defaults");

      // offsets 0x04 to 0x1c including the hole at 0x14
      for (int r = 0; r < 4; r++) begin
         for (int a = 32'h04; a <= 32'h1c; a += 4) begin
            apb_write(reg_addr_t'(a), next_rand());
         end
         apb_write(OFS_DATA_TYPE, next_rand());
         apb_read(OFS_DATA_TYPE);
      end
      end_test("config_writes");

      for (int r = 0; r < 3; r++) begin
         randomize_status();
         for (int a = 32'h20; a <= 32'h5c; a += 4) begin
            apb_read(reg_addr_t'(a));
         end
         apb_read(OFS_R1_RESP);
      end
      end_test("status_reads");

      // read-only and unmapped writes followed by write-only reads
      for (int a = 32'h20; a <= 32'h58; a += 4) begin
         apb_write(reg_addr_t'(a), next_rand());
      end
      apb_write(OFS_R1_RESP, next_rand());
      apb_write(16'h0060, next_rand());
      apb_write(16'h0200, next_rand());
      for (int a = 32'h00; a <= 32'h1c; a += 4) begin
         apb_read(reg_addr_t'(a));
      end
      apb_read(16'h0100);
      apb_read(16'h0016);
      end_test("errors");

      apb_write(OFS_COMMAND, {16'd0, CMD_INIT});
      wait_pulse_end(1'b0);
      apb_write(OFS_SD_ADDR, next_rand());
      apb_write(OFS_COMMAND, {16'd0, CMD_READ});
      repeat (4) @(negedge clk);
      // new card address mid transfer
      apb_write(OFS_SD_ADDR, next_rand());
      wait_pulse_end(1'b1);
      apb_write(OFS_COMMAND, {16'd0, CMD_WRITE});
      wait_pulse_end(1'b1);
      apb_write(OFS_COMMAND, 32'd0);
      apb_write(OFS_COMMAND, 32'd7);
      repeat (4) @(negedge clk);
      end_test("commands");

      apb_write(OFS_COMMAND, {16'd0, CMD_INIT});
      repeat (12) @(negedge clk);
      apb_write(OFS_COMMAND, {16'd0, CMD_INIT});
      // start pulse overlaps the init pulse
      apb_write(OFS_COMMAND, {16'd0, CMD_WRITE});
      wait_pulse_end(1'b0);
      wait_pulse_end(1'b1);
      end_test("retrigger");

      repeat (2) @(negedge clk);
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

//--- files.f
hw/sd_reg_pkg.sv
hw/sd_apb_decode.sv
hw/sd_cfg_regs.sv
hw/sd_cmd_pulse.sv
hw/sd_reg_top.sv
tb/sd_reg_checker.sv
tb/sd_reg_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module sd_reg_tb -f files.f --Mdir obj_dir
./obj_dir/Vsd_reg_tb > sim.log 2>&1
cat sim.log
if grep -q "CHECKS FAILED" sim.log; then
   echo "simulation reported failures"
   exit 1
fi
echo "simulation finished without failures"
